//--- tscCore.f
logic/tscPkg.sv
logic/controlUnit.sv
logic/regFile.sv
logic/decodeStage.sv
logic/aluUnit.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/tscCore.sv
verif/tscCoreTb.sv

//--- Makefile
TOOL       = verilator
TOP        = tscCoreTb
FILELIST   = tscCore.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing --top-module $(TOP)
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --top-module $(TOP)

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tscCoreTb.sv
`timescale 1ns/1ps

module tscCoreTb;

	localparam int memDepth = 64;
	localparam int clkPeriod = 8;
	localparam int resetCycles = 10;
	localparam int retireLag = 3; // Sampling edge to the retire check
	localparam int redirectLag = 2; // Sampling edge to the redirect check
	localparam int aluCount = 40;
	localparam int memRounds = 8;
	localparam int branchRounds = 2;
	localparam int jumpReps = 3;
	// Issue and idle slots of all phases together
	localparam int totalSlots = 16 + aluCount + memRounds * 7 + branchRounds * 40
		+ jumpReps * 4 + 8;
	localparam int timeoutCycles = resetCycles + totalSlots + 60;

	typedef struct packed {
		logic [31:0] due;
		logic [1:0] idx;
		logic [15:0] data;
	} retireT;

	typedef struct packed {
		logic [31:0] due;
		logic [15:0] target;
	} redirectT;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [15:0] instruction;
	logic [15:0] pc;
	logic wbValid;
	logic [1:0] wbReg;
	logic [15:0] wbData;
	logic redirectValid;
	logic [15:0] redirectPc;

	logic [15:0] modelRegs [4];
	logic [15:0] modelMem [memDepth];
	retireT retireQ [$];
	redirectT redirectQ [$];
	logic [15:0] curPc;
	logic [31:0] cyc = '0; // Counts falling edges
	logic expWbValid = 1'b0;
	logic [1:0] expWbReg = '0;
	logic [15:0] expWbData = '0;
	logic expRedValid = 1'b0;
	logic [15:0] expRedPc = '0;

	tscCore #(
		.memDepth(memDepth)
	) i_tscCore (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instruction(instruction),
		.pc(pc), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.redirectValid(redirectValid), .redirectPc(redirectPc)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic reportMismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
		$display("Test failed");
		$fatal(1, "stopping at first mismatch");
	endtask

	function automatic logic [15:0] encImm(input logic [3:0] op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] encReg(input logic [1:0] rs, input logic [1:0] rt,
			input logic [1:0] rd, input logic [5:0] fn);
		return {tscPkg::opRtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] encJump(input logic [3:0] op, input logic [11:0] field);
		return {op, field};
	endfunction

	function automatic logic [1:0] randReg();
		return 2'($urandom_range(0, 3));
	endfunction

	task automatic expectRetire(input logic [1:0] idx, input logic [15:0] data);
		retireT item;
		item.due = cyc + 32'd1 + 32'(retireLag);
		item.idx = idx;
		item.data = data;
		retireQ.push_back(item);
		modelRegs[idx] = data;
	endtask

	task automatic expectRedirect(input logic [15:0] target);
		redirectT item;
		item.due = cyc + 32'd1 + 32'(redirectLag);
		item.target = target;
		redirectQ.push_back(item);
	endtask

	// Architectural effect of one instruction in program order
	task automatic modelStep(input logic [15:0] instr, input logic [15:0] pcVal);
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sext;
		logic [15:0] ea;
		logic [15:0] link;
		int addr;
		logic taken;
		rs = instr[11:10];
		rt = instr[9:8];
		rd = instr[7:6];
		a = modelRegs[rs];
		b = modelRegs[rt];
		sext = {{8{instr[7]}}, instr[7:0]};
		ea = a + sext;
		addr = int'(ea) % memDepth; // Low address bits only
		link = pcVal + 16'd1;
		taken = 1'b0;
		case (instr[15:12])
			4'd0: taken = a != b;
			4'd1: taken = a == b;
			4'd2: taken = $signed(a) > 0;
			4'd3: taken = $signed(a) < 0;
			4'd4: expectRetire(rt, a + sext);
			4'd5: expectRetire(rt, a | {8'h00, instr[7:0]});
			4'd6: expectRetire(rt, {instr[7:0], 8'h00});
			4'd7: expectRetire(rt, modelMem[addr]);
			4'd8: modelMem[addr] = b;
			4'd9: expectRedirect({pcVal[15:12], instr[11:0]});
			4'd10: begin
				expectRedirect({pcVal[15:12], instr[11:0]});
				expectRetire(2'd2, link);
			end
			4'd15: begin
				case (instr[5:0])
					6'd0: expectRetire(rd, a + b);
					6'd1: expectRetire(rd, a - b);
					6'd2: expectRetire(rd, a & b);
					6'd3: expectRetire(rd, a | b);
					6'd4: expectRetire(rd, ~a);
					6'd5: expectRetire(rd, 16'd0 - a);
					6'd6: expectRetire(rd, a << 1);
					6'd7: expectRetire(rd, 16'($signed(a) >>> 1));
					6'd25: expectRedirect(a);
					6'd26: begin
						expectRedirect(a); // Target uses rs before the link write
						expectRetire(2'd2, link);
					end
					default: ;
				endcase
			end
			default: ;
		endcase
		if (taken) begin
			expectRedirect(link + sext);
		end
	endtask

	task automatic issue(input logic [15:0] instr);
		@(posedge clk);
		instrValid <= 1'b1;
		instruction <= instr;
		pc <= curPc;
		modelStep(instr, curPc);
		curPc = curPc + 16'd1;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			instrValid <= 1'b0;
			instruction <= 16'($urandom); // Junk that must be ignored
		end
	endtask

	task automatic loadConst(input logic [1:0] r, input logic [15:0] v);
		issue(encImm(tscPkg::opLhi, 2'd0, r, v[15:8]));
		issue(encImm(tscPkg::opOri, r, r, v[7:0]));
	endtask

	// Expected strobes for the coming cycle
	always @(negedge clk) begin
		cyc = cyc + 32'd1;
		expWbValid = 1'b0;
		expRedValid = 1'b0;
		if (retireQ.size() != 0 && retireQ[0].due == cyc) begin
			expWbValid = 1'b1;
			expWbReg = retireQ[0].idx;
			expWbData = retireQ[0].data;
			void'(retireQ.pop_front());
		end
		if (redirectQ.size() != 0 && redirectQ[0].due == cyc) begin
			expRedValid = 1'b1;
			expRedPc = redirectQ[0].target;
			void'(redirectQ.pop_front());
		end
	end

	wbValidCheck: assert property (@(posedge clk) disable iff (!rstN) wbValid == expWbValid)
		else reportMismatch("wbValid", 16'($sampled(wbValid)), 16'($sampled(expWbValid)));
	wbRegCheck: assert property (@(posedge clk) disable iff (!rstN)
			wbValid |-> wbReg == expWbReg)
		else reportMismatch("wbReg", 16'($sampled(wbReg)), 16'($sampled(expWbReg)));
	wbDataCheck: assert property (@(posedge clk) disable iff (!rstN)
			wbValid |-> wbData == expWbData)
		else reportMismatch("wbData", $sampled(wbData), $sampled(expWbData));
	redValidCheck: assert property (@(posedge clk) disable iff (!rstN)
			redirectValid == expRedValid)
		else reportMismatch("redirectValid", 16'($sampled(redirectValid)),
			16'($sampled(expRedValid)));
	redPcCheck: assert property (@(posedge clk) disable iff (!rstN)
			redirectValid |-> redirectPc == expRedPc)
		else reportMismatch("redirectPc", $sampled(redirectPc), $sampled(expRedPc));

	initial begin
		#(timeoutCycles * clkPeriod);
		$display("Watchdog expired after %0d cycles without finishing", timeoutCycles);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [15:0] r;
		logic [15:0] v1;
		logic [15:0] v2;
		logic [7:0] a8;
		logic [7:0] b8;
		logic [1:0] d1;
		logic [1:0] d2;
		int k;
		int drain;
		void'($urandom(66494));
		rstN = 1'b0;
		instrValid = 1'b0;
		instruction = '0;
		pc = '0;
		curPc = 16'h0100;
		for (int i = 0; i < 4; i++) modelRegs[i] = '0;
		for (int i = 0; i < memDepth; i++) modelMem[i] = '0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;

		idleCycles(5); // Quiet core after reset
		for (int i = 0; i < 4; i++) loadConst(2'(i), 16'($urandom));

		// Back to back ALU traffic hits every forwarding distance
		for (int i = 0; i < aluCount; i++) begin
			k = $urandom_range(0, 9);
			if (k == 8) issue(encImm(tscPkg::opAdi, randReg(), randReg(), 8'($urandom)));
			else if (k == 9) issue(encImm(tscPkg::opLhi, 2'd0, randReg(), 8'($urandom)));
			else issue(encReg(randReg(), randReg(), randReg(), 6'(k)));
		end

		issue(encImm(tscPkg::opLhi, 2'd0, 2'd0, 8'h00)); // $0 as zero base
		for (int i = 0; i < memRounds; i++) begin
			a8 = 8'($urandom);
			b8 = 8'($urandom);
			d1 = 2'($urandom_range(1, 3));
			d2 = 2'($urandom_range(1, 3));
			issue(encImm(tscPkg::opSwd, 2'd0, randReg(), a8));
			issue(encImm(tscPkg::opSwd, 2'd0, randReg(), b8));
			issue(encImm(tscPkg::opLwd, 2'd0, d1, a8));
			idleCycles(1);
			issue(encImm(tscPkg::opLwd, 2'd0, d2, b8));
			idleCycles(1); // Load-use gap
			issue(encReg(d1, d2, 2'($urandom_range(1, 3)), tscPkg::fnAdd));
		end

		for (int round = 0; round < branchRounds; round++) begin
			for (int kind = 0; kind < 4; kind++) begin
				for (int t = 0; t < 2; t++) begin
					r = 16'($urandom);
					v1 = r;
					v2 = 16'($urandom);
					case (kind)
						0, 1: v2 = ((kind == 1) == (t == 1)) ? r : r ^ (v2 | 16'h0001);
						2: v1 = (t == 1) ? ({1'b0, r[14:0]} | 16'h0001)
							: ((round == 0) ? 16'h0000 : {1'b1, r[14:0]});
						default: v1 = (t == 1) ? {1'b1, r[14:0]} : {1'b0, r[14:0]};
					endcase
					loadConst(2'd1, v1);
					loadConst(2'd2, v2);
					issue(encImm(4'(kind), 2'd1, 2'd2, 8'($urandom)));
				end
			end
		end

		curPc = 16'($urandom); // Upper pc bits matter for JMP and JAL
		for (int i = 0; i < jumpReps; i++) begin
			issue(encJump(tscPkg::opJmp, 12'($urandom)));
			issue(encJump(tscPkg::opJal, 12'($urandom)));
			issue(encReg(2'd2, 2'd0, 2'd0, tscPkg::fnJpr)); // Uses the fresh link value
			issue(encReg(randReg(), 2'd0, 2'd0, tscPkg::fnJrl));
		end

		issue(encImm(4'($urandom_range(11, 14)), randReg(), randReg(), 8'($urandom)));
		issue(encReg(randReg(), randReg(), randReg(), 6'($urandom_range(8, 24))));
		issue(encReg(randReg(), randReg(), randReg(), 6'($urandom_range(27, 63))));

		drain = 0;
		while ((retireQ.size() != 0 || redirectQ.size() != 0) && drain < retireLag + 6) begin
			idleCycles(1);
			drain++;
		end
		idleCycles(4);
		if (retireQ.size() == 0 && redirectQ.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Expected strobes were still pending when the run ended");
			$display("Test failed");
			$fatal(1, "pending strobes");
		end
	end

endmodule

//--- logic/tscCore.sv
`timescale 1ns/1ps

module tscCore #(
	parameter int memDepth = 64 // Data memory words
) (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [tscPkg::wordSize-1:0] instruction,
	input logic [tscPkg::wordSize-1:0] pc,
	output logic wbValid,
	output logic [tscPkg::regIdxW-1:0] wbReg,
	output logic [tscPkg::wordSize-1:0] wbData,
	output logic redirectValid,
	output logic [tscPkg::wordSize-1:0] redirectPc
);

	// Decoder outputs
	tscPkg::aluOpE aluOp;
	tscPkg::immModeE immMode;
	logic useImm, regWrite, memRead, memWrite, isBranch, isJump, jumpFromReg, link;
	logic [tscPkg::regIdxW-1:0] wrIdx;
	logic [1:0] branchKind;

	// Register file read side
	logic [tscPkg::regIdxW-1:0] rsIdx, rtIdx;
	logic [tscPkg::wordSize-1:0] rsVal, rtVal;

	// Decode register
	tscPkg::aluOpE dAluOp;
	tscPkg::immModeE dImmMode;
	logic dValid, dUseImm, dRegWrite, dMemRead, dMemWrite;
	logic dIsBranch, dIsJump, dJumpFromReg, dLink;
	logic [tscPkg::regIdxW-1:0] dWrIdx, dRsIdx, dRtIdx;
	logic [1:0] dBranchKind;
	logic [tscPkg::wordSize-1:0] dRsVal, dRtVal, dPc;
	logic [7:0] dImm;
	logic [11:0] dJumpField;

	// Execute register
	logic eValid, eMemRead, eMemWrite, eRegWrite;
	logic [tscPkg::wordSize-1:0] eResult, eStoreData;
	logic [tscPkg::regIdxW-1:0] eWrIdx;

	controlUnit i_controlUnit (
		.instruction(instruction), .aluOp(aluOp), .useImm(useImm), .immMode(immMode),
		.regWrite(regWrite), .wrIdx(wrIdx), .memRead(memRead), .memWrite(memWrite),
		.isBranch(isBranch), .branchKind(branchKind), .isJump(isJump),
		.jumpFromReg(jumpFromReg), .link(link)
	);

	regFile i_regFile (
		.clk(clk), .rstN(rstN), .rdIdxA(rsIdx), .rdIdxB(rtIdx), .wrEn(wbValid),
		.wrIdx(wbReg), .wrData(wbData), .rdDataA(rsVal), .rdDataB(rtVal)
	);

	decodeStage i_decodeStage (
		.clk(clk), .rstN(rstN), .instrValid(instrValid), .instruction(instruction),
		.pc(pc), .rsVal(rsVal), .rtVal(rtVal), .aluOp(aluOp), .useImm(useImm),
		.immMode(immMode), .regWrite(regWrite), .wrIdx(wrIdx), .memRead(memRead),
		.memWrite(memWrite), .isBranch(isBranch), .branchKind(branchKind),
		.isJump(isJump), .jumpFromReg(jumpFromReg), .link(link), .rsIdx(rsIdx),
		.rtIdx(rtIdx), .dValid(dValid), .dAluOp(dAluOp), .dUseImm(dUseImm),
		.dImmMode(dImmMode), .dRegWrite(dRegWrite), .dWrIdx(dWrIdx),
		.dMemRead(dMemRead), .dMemWrite(dMemWrite), .dIsBranch(dIsBranch),
		.dBranchKind(dBranchKind), .dIsJump(dIsJump), .dJumpFromReg(dJumpFromReg),
		.dLink(dLink), .dRsIdx(dRsIdx), .dRtIdx(dRtIdx), .dRsVal(dRsVal),
		.dRtVal(dRtVal), .dImm(dImm), .dJumpField(dJumpField), .dPc(dPc)
	);

	executeStage i_executeStage (
		.clk(clk), .rstN(rstN), .dValid(dValid), .dAluOp(dAluOp), .dUseImm(dUseImm),
		.dImmMode(dImmMode), .dRegWrite(dRegWrite), .dWrIdx(dWrIdx),
		.dMemRead(dMemRead), .dMemWrite(dMemWrite), .dIsBranch(dIsBranch),
		.dBranchKind(dBranchKind), .dIsJump(dIsJump), .dJumpFromReg(dJumpFromReg),
		.dLink(dLink), .dRsIdx(dRsIdx), .dRtIdx(dRtIdx), .dRsVal(dRsVal),
		.dRtVal(dRtVal), .dImm(dImm), .dJumpField(dJumpField), .dPc(dPc),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .eValid(eValid),
		.eResult(eResult), .eStoreData(eStoreData), .eMemRead(eMemRead),
		.eMemWrite(eMemWrite), .eRegWrite(eRegWrite), .eWrIdx(eWrIdx),
		.redirectValid(redirectValid), .redirectPc(redirectPc)
	);

	memWbStage #(
		.memDepth(memDepth)
	) i_memWbStage (
		.clk(clk), .rstN(rstN), .eValid(eValid), .eResult(eResult),
		.eStoreData(eStoreData), .eMemRead(eMemRead), .eMemWrite(eMemWrite),
		.eRegWrite(eRegWrite), .eWrIdx(eWrIdx), .wbValid(wbValid), .wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

//--- logic/memWbStage.sv
`timescale 1ns/1ps

module memWbStage #(
	parameter int memDepth = 64
) (
	input logic clk,
	input logic rstN,
	input logic eValid,
	input logic [tscPkg::wordSize-1:0] eResult,
	input logic [tscPkg::wordSize-1:0] eStoreData,
	input logic eMemRead,
	input logic eMemWrite,
	input logic eRegWrite,
	input logic [tscPkg::regIdxW-1:0] eWrIdx,
	output logic wbValid,
	output logic [tscPkg::regIdxW-1:0] wbReg,
	output logic [tscPkg::wordSize-1:0] wbData
);

	localparam int addrW = $clog2(memDepth);

	logic [tscPkg::wordSize-1:0] mem [memDepth];
	logic [addrW-1:0] addr;
	logic [tscPkg::wordSize-1:0] loadData;

	assign addr = eResult[addrW-1:0]; // Upper address bits ignored
	assign loadData = mem[addr];

	// Memory starts out zeroed
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < memDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (eValid && eMemWrite) begin
			mem[addr] <= eStoreData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= eValid && eRegWrite; // Retire strobe and RF write enable
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= eWrIdx;
		wbData <= eMemRead ? loadData : eResult;
	end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic rstN,
	input logic dValid,
	input tscPkg::aluOpE dAluOp,
	input logic dUseImm,
	input tscPkg::immModeE dImmMode,
	input logic dRegWrite,
	input logic [tscPkg::regIdxW-1:0] dWrIdx,
	input logic dMemRead,
	input logic dMemWrite,
	input logic dIsBranch,
	input logic [1:0] dBranchKind,
	input logic dIsJump,
	input logic dJumpFromReg,
	input logic dLink,
	input logic [tscPkg::regIdxW-1:0] dRsIdx,
	input logic [tscPkg::regIdxW-1:0] dRtIdx,
	input logic [tscPkg::wordSize-1:0] dRsVal,
	input logic [tscPkg::wordSize-1:0] dRtVal,
	input logic [7:0] dImm,
	input logic [11:0] dJumpField,
	input logic [tscPkg::wordSize-1:0] dPc,
	input logic wbValid,
	input logic [tscPkg::regIdxW-1:0] wbReg,
	input logic [tscPkg::wordSize-1:0] wbData,
	output logic eValid,
	output logic [tscPkg::wordSize-1:0] eResult,
	output logic [tscPkg::wordSize-1:0] eStoreData,
	output logic eMemRead,
	output logic eMemWrite,
	output logic eRegWrite,
	output logic [tscPkg::regIdxW-1:0] eWrIdx,
	output logic redirectValid,
	output logic [tscPkg::wordSize-1:0] redirectPc
);

	localparam int w = tscPkg::wordSize;
	localparam logic [w-1:0] one = {{(w-1){1'b0}}, 1'b1};

	logic [w-1:0] fwdA;
	logic [w-1:0] fwdB;
	logic [w-1:0] immOperand;
	logic [w-1:0] opB;
	logic [w-1:0] aluResult;
	logic [w-1:0] pcNext;
	logic [w-1:0] result;
	logic [w-1:0] target;
	logic taken;

	// Nearest older writer wins
	function automatic logic [w-1:0] forward(input logic [tscPkg::regIdxW-1:0] idx,
			input logic [w-1:0] regVal);
		if (eValid && eRegWrite && eWrIdx == idx) begin
			return eResult; // One ahead
		end else if (wbValid && wbReg == idx) begin
			return wbData; // Two ahead
		end
		return regVal;
	endfunction

	always_comb begin
		fwdA = forward(dRsIdx, dRsVal);
		fwdB = forward(dRtIdx, dRtVal);
	end

	always_comb begin
		case (dImmMode)
			tscPkg::immZext: immOperand = {{(w-8){1'b0}}, dImm};
			tscPkg::immHigh: immOperand = {dImm, {(w-8){1'b0}}};
			default: immOperand = {{(w-8){dImm[7]}}, dImm};
		endcase
	end

	assign opB = dUseImm ? immOperand : fwdB;
	assign pcNext = dPc + one;

	aluUnit i_aluUnit (
		.aluOp(dAluOp),
		.opA(fwdA),
		.opB(opB),
		.result(aluResult)
	);

	always_comb begin
		if (dLink) begin
			result = pcNext; // Return address for JAL/JRL
		end else if (dUseImm && dImmMode == tscPkg::immHigh) begin
			result = immOperand; // LHI
		end else begin
			result = aluResult;
		end
	end

	always_comb begin
		case (dBranchKind)
			2'd0: taken = fwdA != fwdB; // BNE
			2'd1: taken = fwdA == fwdB; // BEQ
			2'd2: taken = !fwdA[w-1] && fwdA != '0; // BGZ
			default: taken = fwdA[w-1]; // BLZ
		endcase
	end

	always_comb begin
		if (dIsBranch) begin
			target = pcNext + {{(w-8){dImm[7]}}, dImm};
		end else if (dJumpFromReg) begin
			target = fwdA;
		end else begin
			target = {dPc[w-1:12], dJumpField};
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			eValid <= 1'b0;
			eMemRead <= 1'b0;
			eMemWrite <= 1'b0;
			eRegWrite <= 1'b0;
			redirectValid <= 1'b0;
		end else begin
			eValid <= dValid;
			eMemRead <= dValid && dMemRead;
			eMemWrite <= dValid && dMemWrite;
			eRegWrite <= dValid && dRegWrite;
			redirectValid <= dValid && (dIsJump || (dIsBranch && taken));
		end
	end

	always_ff @(posedge clk) begin
		eResult <= result;
		eStoreData <= fwdB; // rt for SWD
		eWrIdx <= dWrIdx;
		redirectPc <= target;
	end

endmodule

//--- logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input tscPkg::aluOpE aluOp,
	input logic [tscPkg::wordSize-1:0] opA,
	input logic [tscPkg::wordSize-1:0] opB,
	output logic [tscPkg::wordSize-1:0] result
);

	localparam int w = tscPkg::wordSize;

	always_comb begin
		case (aluOp)
			tscPkg::aluAdd: result = opA + opB;
			tscPkg::aluSub: result = opA - opB;
			tscPkg::aluAnd: result = opA & opB;
			tscPkg::aluOr: result = opA | opB;
			tscPkg::aluNot: result = ~opA;
			tscPkg::aluTcp: result = -opA; // Negate rs
			tscPkg::aluShl: result = {opA[w-2:0], 1'b0};
			tscPkg::aluShr: result = {opA[w-1], opA[w-1:1]}; // Keeps the sign
			default: result = '0; // aluZero
		endcase
	end

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [tscPkg::wordSize-1:0] instruction,
	input logic [tscPkg::wordSize-1:0] pc,
	input logic [tscPkg::wordSize-1:0] rsVal,
	input logic [tscPkg::wordSize-1:0] rtVal,
	input tscPkg::aluOpE aluOp,
	input logic useImm,
	input tscPkg::immModeE immMode,
	input logic regWrite,
	input logic [tscPkg::regIdxW-1:0] wrIdx,
	input logic memRead,
	input logic memWrite,
	input logic isBranch,
	input logic [1:0] branchKind,
	input logic isJump,
	input logic jumpFromReg,
	input logic link,
	output logic [tscPkg::regIdxW-1:0] rsIdx,
	output logic [tscPkg::regIdxW-1:0] rtIdx,
	output logic dValid,
	output tscPkg::aluOpE dAluOp,
	output logic dUseImm,
	output tscPkg::immModeE dImmMode,
	output logic dRegWrite,
	output logic [tscPkg::regIdxW-1:0] dWrIdx,
	output logic dMemRead,
	output logic dMemWrite,
	output logic dIsBranch,
	output logic [1:0] dBranchKind,
	output logic dIsJump,
	output logic dJumpFromReg,
	output logic dLink,
	output logic [tscPkg::regIdxW-1:0] dRsIdx,
	output logic [tscPkg::regIdxW-1:0] dRtIdx,
	output logic [tscPkg::wordSize-1:0] dRsVal,
	output logic [tscPkg::wordSize-1:0] dRtVal,
	output logic [7:0] dImm,
	output logic [11:0] dJumpField,
	output logic [tscPkg::wordSize-1:0] dPc
);

	assign rsIdx = instruction[11:10]; // To regFile read ports
	assign rtIdx = instruction[9:8];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dValid <= 1'b0;
		end else begin
			dValid <= instrValid; // Bubble when no strobe
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			dAluOp <= aluOp;
			dUseImm <= useImm;
			dImmMode <= immMode;
			dRegWrite <= regWrite;
			dWrIdx <= wrIdx;
			dMemRead <= memRead;
			dMemWrite <= memWrite;
			dIsBranch <= isBranch;
			dBranchKind <= branchKind;
			dIsJump <= isJump;
			dJumpFromReg <= jumpFromReg;
			dLink <= link;
			dRsIdx <= rsIdx;
			dRtIdx <= rtIdx;
			dRsVal <= rsVal;
			dRtVal <= rtVal;
			dImm <= instruction[7:0];
			dJumpField <= instruction[11:0]; // Low twelve bits for JMP/JAL
			dPc <= pc;
		end
	end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic [tscPkg::regIdxW-1:0] rdIdxA,
	input logic [tscPkg::regIdxW-1:0] rdIdxB,
	input logic wrEn,
	input logic [tscPkg::regIdxW-1:0] wrIdx,
	input logic [tscPkg::wordSize-1:0] wrData,
	output logic [tscPkg::wordSize-1:0] rdDataA,
	output logic [tscPkg::wordSize-1:0] rdDataB
);

	localparam int numRegs = 1 << tscPkg::regIdxW;

	logic [tscPkg::wordSize-1:0] regs [numRegs];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// Write-through covers a writer three instructions ahead
	assign rdDataA = (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
	assign rdDataB = (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input logic [tscPkg::wordSize-1:0] instruction,
	output tscPkg::aluOpE aluOp,
	output logic useImm,
	output tscPkg::immModeE immMode,
	output logic regWrite,
	output logic [tscPkg::regIdxW-1:0] wrIdx,
	output logic memRead,
	output logic memWrite,
	output logic isBranch,
	output logic [1:0] branchKind,
	output logic isJump,
	output logic jumpFromReg,
	output logic link
);

	localparam logic [tscPkg::regIdxW-1:0] linkReg = 2; // JAL and JRL write $2

	tscPkg::opcodeE opcode;
	tscPkg::funcE func;
	logic [tscPkg::regIdxW-1:0] rtField;
	logic [tscPkg::regIdxW-1:0] rdField;

	assign opcode = tscPkg::opcodeE'(instruction[15:12]);
	assign func = tscPkg::funcE'(instruction[5:0]);
	assign rtField = instruction[9:8];
	assign rdField = instruction[7:6];
	assign branchKind = instruction[13:12]; // Selects BNE/BEQ/BGZ/BLZ

	always_comb begin
		aluOp = tscPkg::aluZero; // Everything idle unless decoded below
		useImm = 1'b0;
		immMode = tscPkg::immSext;
		regWrite = 1'b0;
		wrIdx = rtField;
		memRead = 1'b0;
		memWrite = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		jumpFromReg = 1'b0;
		link = 1'b0;
		case (opcode)
			tscPkg::opRtype: begin
				case (func)
					tscPkg::fnAdd: aluOp = tscPkg::aluAdd;
					tscPkg::fnSub: aluOp = tscPkg::aluSub;
					tscPkg::fnAnd: aluOp = tscPkg::aluAnd;
					tscPkg::fnOrr: aluOp = tscPkg::aluOr;
					tscPkg::fnNot: aluOp = tscPkg::aluNot;
					tscPkg::fnTcp: aluOp = tscPkg::aluTcp;
					tscPkg::fnShl: aluOp = tscPkg::aluShl;
					tscPkg::fnShr: aluOp = tscPkg::aluShr;
					tscPkg::fnJpr: begin
						isJump = 1'b1;
						jumpFromReg = 1'b1;
					end
					tscPkg::fnJrl: begin
						isJump = 1'b1;
						jumpFromReg = 1'b1;
						link = 1'b1;
						regWrite = 1'b1;
						wrIdx = linkReg;
					end
					default: ; // Unknown function retires nothing
				endcase
				if (aluOp != tscPkg::aluZero) begin
					// Only arithmetic functions pick a non-zero op
					regWrite = 1'b1;
					wrIdx = rdField;
				end
			end
			tscPkg::opAdi: begin
				aluOp = tscPkg::aluAdd;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			tscPkg::opOri: begin
				aluOp = tscPkg::aluOr;
				useImm = 1'b1;
				immMode = tscPkg::immZext;
				regWrite = 1'b1;
			end
			tscPkg::opLhi: begin
				useImm = 1'b1; // Result is the shifted immediate itself
				immMode = tscPkg::immHigh;
				regWrite = 1'b1;
			end
			tscPkg::opLwd: begin
				aluOp = tscPkg::aluAdd; // Address is rs + sext imm
				useImm = 1'b1;
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			tscPkg::opSwd: begin
				aluOp = tscPkg::aluAdd;
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			tscPkg::opBne, tscPkg::opBeq, tscPkg::opBgz, tscPkg::opBlz: isBranch = 1'b1;
			tscPkg::opJmp: isJump = 1'b1;
			tscPkg::opJal: begin
				isJump = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
				wrIdx = linkReg;
			end
			default: ; // Unknown opcode
		endcase
	end

endmodule

//--- logic/tscPkg.sv
package tscPkg;

	localparam int wordSize = 16; // Data and address width
	localparam int regIdxW = 2; // Four architectural registers

	// Instruction bits 15..12
	typedef enum logic [3:0] {
		opBne = 4'd0,
		opBeq = 4'd1,
		opBgz = 4'd2,
		opBlz = 4'd3,
		opAdi = 4'd4,
		opOri = 4'd5,
		opLhi = 4'd6,
		opLwd = 4'd7,
		opSwd = 4'd8,
		opJmp = 4'd9,
		opJal = 4'd10,
		opRtype = 4'd15
	} opcodeE;

	// R-type function field, bits 5..0
	typedef enum logic [5:0] {
		fnAdd = 6'd0,
		fnSub = 6'd1,
		fnAnd = 6'd2,
		fnOrr = 6'd3,
		fnNot = 6'd4,
		fnTcp = 6'd5,
		fnShl = 6'd6,
		fnShr = 6'd7,
		fnJpr = 6'd25,
		fnJrl = 6'd26
	} funcE;

	typedef enum logic [3:0] {
		aluZero, // Pass zero
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNot,
		aluTcp, // Two's complement of opA
		aluShl,
		aluShr // Arithmetic
	} aluOpE;

	typedef enum logic [1:0] {
		immSext, // Sign-extended low byte
		immZext, // Zero-extended low byte
		immHigh // Byte in the upper half
	} immModeE;

endpackage
